// ==== design/tilemap_consts.svh ====
// Reduced raster for simulation; ROM must answer within the budget, there is no stall path
`ifndef TILEMAP_CONSTS_SVH
`define TILEMAP_CONSTS_SVH

// Screen raster, in pixels and lines
`define TM_H_TOTAL    96
`define TM_H_VISIBLE  64
`define TM_V_TOTAL    40
`define TM_V_VISIBLE  32

// Sync pulse placement
`define TM_HS_START   72
`define TM_HS_LEN     8
`define TM_VS_START   34
`define TM_VS_LEN     2

// Map RAM word address width, 32 by 32 tiles
`define TM_MAP_AW     10

// Pixels the fetch runs ahead of the output
`define TM_LEAD       16

// Max clocks from rom_cs to rom_ok
`define TM_ROM_BUDGET 10

`endif

// ==== design/cpu_bus_pkg.sv ====
// CPU side types only; one request per clock, no wait states on the bus
package cpu_bus_pkg;

    // Which block a request targets, decoded from the chip selects
    typedef enum logic [1:0] {
        sel_none   = 2'd0,
        sel_mode   = 2'd1,
        sel_scroll = 2'd2,
        sel_map    = 2'd3
    } reg_sel_e;

    // One CPU access as seen in a single clock
    typedef struct packed {
        reg_sel_e    sel;
        logic [12:1] addr;   // Word address
        logic [15:0] wdata;
        logic        rnw;    // High for read
        logic [1:0]  dsn;    // Byte strobes, active low, [1] is upper byte
    } cpu_req_t;

endpackage

// ==== design/video_pkg.sv ====
// Video side types only; coordinates are 9 bits, palette index goes out without a palette RAM
package video_pkg;

    // Timer outputs, all in the clk domain
    typedef struct packed {
        logic       cen;     // Pixel enable, 1 in 2 clocks
        logic [8:0] hdump;
        logic [8:0] vdump;
        logic       hblank;
        logic       vblank;
        logic       hs;
        logic       vs;
    } vtimer_t;

    // One map RAM word
    typedef struct packed {
        logic [3:0]  palette;
        logic [11:0] code;
    } map_entry_t;

    // Scroll controls decoded from the scroll registers
    typedef struct packed {
        logic [8:0] scroll_x;
        logic [8:0] scroll_y;
    } scroll_t;

    // Output pixel tagged with its screen position
    typedef struct packed {
        logic       valid;
        logic [8:0] h;
        logic [8:0] v;
        logic [3:0] palette;
        logic [3:0] colour;
    } pixel_t;

endpackage

// ==== design/tile_mmr.sv ====
// Only mode 0 bit 0 and mode 1 bits 1:0 steer logic; mode bytes ignore the upper strobe
`timescale 1ns/1ps

module tile_mmr (
    input  logic                  clk,
    input  logic                  rst,
    input  cpu_bus_pkg::cpu_req_t req,
    output logic [15:0]           rdata,
    output logic                  layer_en,
    output logic [1:0]            rom_bank,
    output video_pkg::scroll_t    scroll
);

    logic [3:0][7:0]  mode_q;     // Four mode bytes
    logic [3:0][15:0] scroll_q;   // Four scroll words
    logic [1:0]       idx;
    logic             wr;

    assign idx = req.addr[2:1];
    assign wr  = ~req.rnw;

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q   <= '0;
            scroll_q <= '0;
        end else begin
            if (wr && req.sel == cpu_bus_pkg::sel_mode && !req.dsn[0])
                mode_q[idx] <= req.wdata[7:0];   // Lower byte only
            if (wr && req.sel == cpu_bus_pkg::sel_scroll) begin
                if (!req.dsn[0])
                    scroll_q[idx][7:0]  <= req.wdata[7:0];
                if (!req.dsn[1])
                    scroll_q[idx][15:8] <= req.wdata[15:8];
            end
        end
    end

    // Read-back, valid the clock after the request
    always_ff @(posedge clk) begin
        if (req.sel == cpu_bus_pkg::sel_scroll)
            rdata <= scroll_q[idx];
        else
            rdata <= {8'hff, mode_q[idx]};   // Mode reads with upper byte set
    end

    // Controls for the renderer
    assign layer_en        = mode_q[0][0];
    assign rom_bank        = mode_q[1][1:0];
    assign scroll.scroll_x = scroll_q[0][8:0];   // Register 0 is X
    assign scroll.scroll_y = scroll_q[1][8:0];   // Register 1 is Y

    // No strobe means no scroll write, seen a clock later
    a_scroll_no_strobe: assert property (@(posedge clk) disable iff (rst)
        (req.sel == cpu_bus_pkg::sel_scroll && req.dsn == 2'b11) |=> $stable(scroll_q));

endmodule

// ==== design/tile_map_ram.sv ====
// 32 by 32 map of 16-bit words; both ports read synchronously, render port never writes
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module tile_map_ram (
    input  logic                    clk,
    input  cpu_bus_pkg::cpu_req_t   req,
    output logic [15:0]             cpu_rdata,
    input  logic [`TM_MAP_AW-1:0]   rd_addr,
    output video_pkg::map_entry_t   rd_entry
);

    logic [15:0]            mem [1 << `TM_MAP_AW];
    logic [`TM_MAP_AW-1:0]  cpu_addr;
    logic [1:0]             we;

    assign cpu_addr = req.addr[`TM_MAP_AW:1];
    // Per-byte write enable, strobes are active low
    assign we = {2{~req.rnw && req.sel == cpu_bus_pkg::sel_map}} & ~req.dsn;

    // CPU port
    always_ff @(posedge clk) begin
        if (we[0])
            mem[cpu_addr][7:0]  <= req.wdata[7:0];
        if (we[1])
            mem[cpu_addr][15:8] <= req.wdata[15:8];
        cpu_rdata <= mem[cpu_addr];   // Old data on a write cycle
    end

    // Render port, entry one clock after the address
    always_ff @(posedge clk) begin
        rd_entry <= mem[rd_addr];
    end

endmodule

// ==== design/video_timer.sv ====
// Pixel enable is clk/2 with no external divider; counters start at zero after reset
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module video_timer (
    input  logic                clk,
    input  logic                rst,
    output video_pkg::vtimer_t  timer,
    output logic                pxl2_cen
);

    logic       tog;
    logic       pxl_cen;
    logic [8:0] hcnt;
    logic [8:0] vcnt;

    // Enables, pixel enable first high on the second clock out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            tog      <= 1'b0;
            pxl_cen  <= 1'b0;
            pxl2_cen <= 1'b0;
        end else begin
            pxl2_cen <= 1'b1;
            tog      <= ~tog;
            pxl_cen  <= tog;
        end
    end

    // Raster counters
    always_ff @(posedge clk) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            if (hcnt == 9'(`TM_H_TOTAL - 1)) begin
                hcnt <= '0;
                vcnt <= (vcnt == 9'(`TM_V_TOTAL - 1)) ? 9'd0 : vcnt + 9'd1;   // Frame wrap
            end else begin
                hcnt <= hcnt + 9'd1;
            end
        end
    end

    assign timer.cen    = pxl_cen;
    assign timer.hdump  = hcnt;
    assign timer.vdump  = vcnt;
    assign timer.hblank = hcnt >= 9'(`TM_H_VISIBLE);
    assign timer.vblank = vcnt >= 9'(`TM_V_VISIBLE);
    // Sync pulses inside the blanking
    assign timer.hs = hcnt >= 9'(`TM_HS_START) && hcnt < 9'(`TM_HS_START + `TM_HS_LEN);
    assign timer.vs = vcnt >= 9'(`TM_VS_START) && vcnt < 9'(`TM_VS_START + `TM_VS_LEN);

endmodule

// ==== design/tile_render.sv ====
// Scroll is modulo 256; registers should change in vertical blank; ROM must answer in budget
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module tile_render (
    input  logic                   clk,
    input  logic                   rst,
    input  video_pkg::vtimer_t     timer,
    input  logic                   layer_en,
    input  logic [1:0]             rom_bank,
    input  video_pkg::scroll_t     scroll,
    output logic [`TM_MAP_AW-1:0]  map_addr,
    input  video_pkg::map_entry_t  map_entry,
    output logic                   rom_cs,
    output logic [16:0]            rom_addr,
    input  logic [31:0]            rom_data,
    input  logic                   rom_ok,
    output video_pkg::pixel_t      pixel
);

    typedef enum logic [1:0] {st_idle, st_map, st_rom} fetch_st_e;

    fetch_st_e  st;
    logic [8:0] h;
    logic [8:0] v;
    logic       pre;         // Last 7 pixels of a line, lead-in of the next
    logic [8:0] fv;
    logic       trig;
    logic [7:0] sx;
    logic [7:0] sy;
    logic       pend;
    logic [2:0] pend_row;
    logic [2:0] fetch_row;
    logic       take;
    logic       push;
    logic       pop;
    logic [1:0] cnt;         // Rows held
    logic       wr_ptr;
    logic       rd_ptr;
    logic [3:0]  q_pal  [2];
    logic [31:0] q_data [2];
    logic [3:0]  cur_pal;
    logic [8:0] oh;
    logic [8:0] ov;
    logic       o_vis;
    logic [2:0] ox;

    assign h = timer.hdump;
    assign v = timer.vdump;

    // Fetch side runs at the timer, LEAD ahead of the output
    assign pre = h >= 9'(`TM_H_TOTAL - 7);
    assign fv  = !pre ? v : (v == 9'(`TM_V_TOTAL - 1)) ? 9'd0 : v + 9'd1;
    assign sx  = 8'(h) + 8'(scroll.scroll_x) - (pre ? 8'(`TM_H_TOTAL) : 8'd0);
    assign sy  = 8'(fv) + 8'(scroll.scroll_y);
    assign trig = timer.cen && fv < 9'(`TM_V_VISIBLE)
                && (h < 9'(`TM_H_VISIBLE) || pre) && sx[2:0] == 3'd0;   // Tile boundary

    assign take = st == st_idle && pend && cnt != 2'd2;
    assign push = st == st_rom && rom_ok;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend <= 1'b0;
        end else if (trig) begin
            pend <= 1'b1;
        end else if (take) begin
            pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (trig) begin
            map_addr <= {sy[7:3], sx[7:3]};   // Row-major 32 by 32
            pend_row <= sy[2:0];
        end
        if (take)
            fetch_row <= pend_row;
        if (st == st_map) begin
            rom_addr <= {rom_bank, map_entry.code, fetch_row};   // Bank, code, row
            cur_pal  <= map_entry.palette;
        end
        if (push) begin
            q_pal[wr_ptr]  <= cur_pal;
            q_data[wr_ptr] <= rom_data;
        end
    end

    // Fetch FSM, one map read then one ROM row
    always_ff @(posedge clk) begin
        if (rst) begin
            st     <= st_idle;
            rom_cs <= 1'b0;
        end else begin
            case (st)
                st_idle: if (take) st <= st_map;   // Entry valid next clock
                st_map: begin
                    st     <= st_rom;
                    rom_cs <= 1'b1;
                end
                st_rom: if (rom_ok) begin
                    st     <= st_idle;
                    rom_cs <= 1'b0;
                end
                default: st <= st_idle;
            endcase
        end
    end

    // Output side, LEAD pixels behind the timer
    assign oh = (h >= 9'(`TM_LEAD)) ? h - 9'(`TM_LEAD) : h + 9'(`TM_H_TOTAL - `TM_LEAD);
    assign ov = (h >= 9'(`TM_LEAD)) ? v
              : (v == 9'd0) ? 9'(`TM_V_TOTAL - 1) : v - 9'd1;
    assign o_vis = oh < 9'(`TM_H_VISIBLE) && ov < 9'(`TM_V_VISIBLE);
    assign ox    = 3'(oh) + 3'(scroll.scroll_x);
    // Row done at its last pixel or at line end
    assign pop = timer.cen && o_vis && (ox == 3'd7 || oh == 9'(`TM_H_VISIBLE - 1));

    // Two-deep row queue
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= '0;
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
        end else begin
            cnt <= cnt + 2'(push) - 2'(pop);
            if (push)
                wr_ptr <= ~wr_ptr;
            if (pop)
                rd_ptr <= ~rd_ptr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            pixel.valid <= 1'b0;
        else
            pixel.valid <= timer.cen && o_vis;   // One-clock strobe per pixel
        if (timer.cen) begin
            pixel.h       <= oh;
            pixel.v       <= ov;
            pixel.palette <= layer_en ? q_pal[rd_ptr] : 4'd0;
            pixel.colour  <= layer_en ? q_data[rd_ptr][4*ox +: 4] : 4'd0;   // Pixel n at 4n
        end
    end

    a_rom_budget: assert property (@(posedge clk) disable iff (rst)
        $rose(rom_cs) |-> ##[0:`TM_ROM_BUDGET] rom_ok);

    a_rom_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (rom_cs && !rom_ok) |=> $stable(rom_addr));

endmodule

// ==== design/bac06_tilemap.sv ====
// Single clock for CPU and video; cpu_din is valid one clock after the chip select
`timescale 1ns/1ps

module bac06_tilemap (
    input  logic                clk,
    input  logic                rst,
    input  logic                mode_cs,
    input  logic                sft_cs,    // Scroll registers
    input  logic                map_cs,
    input  logic [15:0]         cpu_dout,
    input  logic [12:1]         cpu_addr,
    input  logic                cpu_rnw,
    input  logic [1:0]          cpu_dsn,
    output logic [15:0]         cpu_din,
    output video_pkg::vtimer_t  timer,
    output logic                pxl2_cen,
    output logic                rom_cs,
    output logic [16:0]         rom_addr,
    input  logic [31:0]         rom_data,
    input  logic                rom_ok,
    output video_pkg::pixel_t   pixel
);

    cpu_bus_pkg::cpu_req_t  req;
    cpu_bus_pkg::reg_sel_e  sel_q;     // Select of the last request
    logic [15:0]            mmr_rdata;
    logic [15:0]            ram_rdata;
    logic                   layer_en;
    logic [1:0]             rom_bank;
    video_pkg::scroll_t     scroll;
    logic [9:0]             map_addr;
    video_pkg::map_entry_t  map_entry;

    assign req.sel   = mode_cs ? cpu_bus_pkg::sel_mode
                     : sft_cs  ? cpu_bus_pkg::sel_scroll
                     : map_cs  ? cpu_bus_pkg::sel_map : cpu_bus_pkg::sel_none;
    assign req.addr  = cpu_addr;
    assign req.wdata = cpu_dout;
    assign req.rnw   = cpu_rnw;
    assign req.dsn   = cpu_dsn;

    always_ff @(posedge clk) begin
        if (rst)
            sel_q <= cpu_bus_pkg::sel_none;
        else
            sel_q <= req.sel;
    end

    // Read-back mux, map RAM or registers
    assign cpu_din = (sel_q == cpu_bus_pkg::sel_map)  ? ram_rdata
                   : (sel_q == cpu_bus_pkg::sel_none) ? 16'd0 : mmr_rdata;

    tile_mmr u_mmr (
        .clk(clk), .rst(rst), .req(req), .rdata(mmr_rdata),
        .layer_en(layer_en), .rom_bank(rom_bank), .scroll(scroll)
    );

    tile_map_ram u_map (
        .clk(clk), .req(req), .cpu_rdata(ram_rdata),
        .rd_addr(map_addr), .rd_entry(map_entry)
    );

    video_timer u_timer (.clk(clk), .rst(rst), .timer(timer), .pxl2_cen(pxl2_cen));

    tile_render u_render (
        .clk(clk), .rst(rst), .timer(timer), .layer_en(layer_en), .rom_bank(rom_bank),
        .scroll(scroll), .map_addr(map_addr), .map_entry(map_entry), .rom_cs(rom_cs),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok), .pixel(pixel)
    );

endmodule

// ==== tests/bac06_tilemap_tb.sv ====
// ROM model answers in 1 to 8 clocks; scroll and layer registers change only in vertical blank
`timescale 1ns/1ps
`include "tilemap_consts.svh"

module bac06_tilemap_tb;

    logic               clk;
    logic               rst;
    logic               mode_cs;
    logic               sft_cs;
    logic               map_cs;
    logic [15:0]        cpu_dout;
    logic [12:1]        cpu_addr;
    logic               cpu_rnw;
    logic [1:0]         cpu_dsn;
    logic [15:0]        cpu_din;
    video_pkg::vtimer_t timer;
    logic               pxl2_cen;
    logic               rom_cs;
    logic [16:0]        rom_addr;
    logic [31:0]        rom_data;
    logic               rom_ok;
    video_pkg::pixel_t  pixel;

    logic [7:0]  mode_m [4];                   // Mirrors of the DUT registers
    logic [15:0] scroll_m [4];
    logic [15:0] map_m [1 << `TM_MAP_AW];
    logic [3:0]  rom_delay [256];              // Reply latency per ROM request
    logic [7:0]  rom_idx;
    int          rom_wait;
    int          post_rst;                     // Clocks since reset release
    int          cs_run;                       // Clocks rom_cs has been high
    int          checked;
    logic        count_en;
    int          seen [`TM_H_VISIBLE][`TM_V_VISIBLE];
    logic [7:0]  exp_pc;
    logic [8:0]  prev_h;
    logic [8:0]  prev_v;
    logic [8:0]  exp_h;
    logic [8:0]  exp_v;
    logic        prev_cen;

    bac06_tilemap u_bac06_tilemap (
        .clk(clk), .rst(rst), .mode_cs(mode_cs), .sft_cs(sft_cs), .map_cs(map_cs),
        .cpu_dout(cpu_dout), .cpu_addr(cpu_addr), .cpu_rnw(cpu_rnw), .cpu_dsn(cpu_dsn),
        .cpu_din(cpu_din), .timer(timer), .pxl2_cen(pxl2_cen), .rom_cs(rom_cs),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok), .pixel(pixel)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    // ROM row for an address, every nibble folds in the whole address
    function automatic logic [31:0] rom_word(input logic [16:0] a);
        logic [3:0]  fold;
        logic [31:0] w;
        fold = a[3:0] ^ a[7:4] ^ a[11:8] ^ a[15:12] ^ {3'b000, a[16]};
        for (int n = 0; n < 8; n++)
            w[4*n +: 4] = fold ^ 4'(n * 5) ^ 4'(a >> n);   // Pixel n differs per column
        return w;
    endfunction

    // Expected {palette, colour} at screen (h, v)
    function automatic logic [7:0] ref_pixel(input logic [8:0] h, input logic [8:0] v);
        logic [7:0]  sx;
        logic [7:0]  sy;
        logic [15:0] entry;
        logic [31:0] row;
        if (!mode_m[0][0])
            return 8'h00;                          // Layer off
        sx    = 8'(h) + scroll_m[0][7:0];          // Wraps at 256
        sy    = 8'(v) + scroll_m[1][7:0];
        entry = map_m[{sy[7:3], sx[7:3]}];         // 32 tiles per map row
        row   = rom_word({mode_m[1][1:0], entry[11:0], sy[2:0]});
        return {entry[15:12], row[4*sx[2:0] +: 4]};
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] data,
                                          input logic [1:0] dsn);
        return {dsn[1] ? old[15:8] : data[15:8], dsn[0] ? old[7:0] : data[7:0]};
    endfunction

    // Kind 0 mode, 1 scroll, 2 map; unused address bits get noise
    function automatic logic [12:1] bus_addr(input int kind, input int idx);
        if (kind == 2)
            return {2'($urandom), 10'(idx)};
        return {10'($urandom), 2'(idx)};
    endfunction

    task automatic cpu_access(input int kind, input logic [12:1] addr, input logic [15:0] data,
                              input logic rnw, input logic [1:0] dsn);
        @(negedge clk);
        mode_cs  = kind == 0;
        sft_cs   = kind == 1;
        map_cs   = kind == 2;
        cpu_addr = addr;
        cpu_dout = data;
        cpu_rnw  = rnw;
        cpu_dsn  = dsn;
        @(negedge clk);                            // Read data is up by now
        mode_cs  = 1'b0;
        sft_cs   = 1'b0;
        map_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_dsn  = 2'b11;
    endtask

    task automatic bus_write(input int kind, input int idx, input logic [15:0] data,
                             input logic [1:0] dsn);
        cpu_access(kind, bus_addr(kind, idx), data, 1'b0, dsn);
        if (kind == 0 && !dsn[0])
            mode_m[idx] = data[7:0];               // No upper byte in a mode register
        else if (kind == 1)
            scroll_m[idx] = merge(scroll_m[idx], data, dsn);
        else if (kind == 2)
            map_m[idx] = merge(map_m[idx], data, dsn);
    endtask

    task automatic bus_check(input int kind, input int idx);
        logic [15:0] exp;
        cpu_access(kind, bus_addr(kind, idx), 16'($urandom), 1'b1, 2'b00);
        exp = (kind == 0) ? {8'hff, mode_m[idx]} : (kind == 1) ? scroll_m[idx] : map_m[idx];
        assert (cpu_din == exp) else stop_on_error($sformatf(
            "ERROR cpu_din kind %0d index %0d: got %h expected %h", kind, idx, cpu_din, exp));
    endtask

    task automatic set_layer(input logic en, input logic [1:0] bank,
                             input logic [15:0] sx, input logic [15:0] sy);
        bus_write(0, 0, 16'(en), 2'b00);
        bus_write(0, 1, 16'(bank), 2'b00);
        bus_write(1, 0, sx, 2'b00);
        bus_write(1, 1, sy, 2'b00);
    endtask

    // Returns on the first clock of vertical blank
    task automatic wait_vblank_start();
        int n;
        n = 0;
        while (timer.vblank) begin
            @(negedge clk);
            n++;
            if (n > 20000)
                stop_on_error("timeout waiting for active video");
        end
        n = 0;
        while (!timer.vblank) begin
            @(negedge clk);
            n++;
            if (n > 20000)
                stop_on_error("timeout waiting for vertical blank");
        end
    endtask

    task automatic register_test();
        int          kind;
        int          idx;
        logic [1:0]  dsn;
        for (int r = 0; r < 8; r++) begin
            bus_write(r / 4, r % 4, 16'($urandom), 2'b00);
            bus_check(r / 4, r % 4);
        end
        for (int i = 0; i < 16; i++) begin
            kind = $urandom % 2;
            idx  = $urandom % 4;
            dsn  = 2'($urandom % 4);               // Any strobe pair, none at all included
            bus_write(kind, idx, 16'($urandom), dsn);
            bus_check(kind, idx);
        end
    endtask

    task automatic map_test();
        int          idx;
        logic [1:0]  dsn;
        for (int i = 0; i < (1 << `TM_MAP_AW); i++)
            bus_write(2, i, 16'($urandom), 2'b00);
        for (int i = 0; i < 64; i++) begin
            idx = $urandom % (1 << `TM_MAP_AW);
            dsn = 2'($urandom % 3);
            bus_write(2, idx, 16'($urandom), dsn);
            bus_check(2, idx);
        end
        for (int i = 0; i < (1 << `TM_MAP_AW); i++)
            bus_check(2, i);
    endtask

    // ROM model with a latency table
    always @(negedge clk) begin
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            rom_wait++;
            if (rom_wait >= rom_delay[rom_idx]) begin
                rom_data = rom_word(rom_addr);
                rom_ok   = 1'b1;
                rom_wait = 0;
                rom_idx  = rom_idx + 8'd1;
            end
        end
    end

    always @(posedge clk)
        post_rst <= rst ? 0 : post_rst + 1;

    // Enables, counters, blanking, syncs and the ROM budget
    always @(negedge clk) begin
        if (post_rst != 0) begin
            assert (pxl2_cen) else stop_on_error("ERROR pxl2_cen: got 0 expected 1");
            assert (timer.cen == (post_rst % 2 == 0)) else stop_on_error($sformatf(
                "ERROR timer.cen: got %h expected %h", timer.cen, post_rst % 2 == 0));
            if (post_rst > 1) begin
                exp_h = prev_cen ? 9'((prev_h + 1) % `TM_H_TOTAL) : prev_h;
                exp_v = (prev_cen && prev_h == `TM_H_TOTAL - 1)
                      ? 9'((prev_v + 1) % `TM_V_TOTAL) : prev_v;
                assert (timer.hdump == exp_h && timer.vdump == exp_v) else
                    stop_on_error($sformatf("ERROR timer.hdump/vdump: got %h/%h expected %h/%h",
                        timer.hdump, timer.vdump, exp_h, exp_v));
            end
            assert (timer.hblank == (timer.hdump >= `TM_H_VISIBLE)
                    && timer.vblank == (timer.vdump >= `TM_V_VISIBLE))
                else stop_on_error($sformatf("ERROR timer.hblank/vblank: got %h/%h at %h/%h",
                    timer.hblank, timer.vblank, timer.hdump, timer.vdump));
            assert (timer.hs == (timer.hdump >= `TM_HS_START
                    && timer.hdump < `TM_HS_START + `TM_HS_LEN))
                else stop_on_error($sformatf("ERROR timer.hs: got %h at hdump %h",
                    timer.hs, timer.hdump));
            assert (timer.vs == (timer.vdump >= `TM_VS_START
                    && timer.vdump < `TM_VS_START + `TM_VS_LEN))
                else stop_on_error($sformatf("ERROR timer.vs: got %h at vdump %h",
                    timer.vs, timer.vdump));
            cs_run = rom_cs ? cs_run + 1 : 0;
            assert (cs_run <= `TM_ROM_BUDGET)
                else stop_on_error("rom_cs stayed high longer than the ROM budget");
        end
        prev_h   = timer.hdump;
        prev_v   = timer.vdump;
        prev_cen = timer.cen;
    end

    // Pixel compare against the reference
    always @(negedge clk) begin
        if (pixel.valid) begin
            assert (pixel.h < `TM_H_VISIBLE && pixel.v < `TM_V_VISIBLE) else
                stop_on_error($sformatf("pixel tagged outside the visible area at (%0d,%0d)",
                    pixel.h, pixel.v));
            // Timer is LEAD enables on, plus the enable that just passed
            assert (timer.hdump == pixel.h + `TM_LEAD + 1 && timer.vdump == pixel.v) else
                stop_on_error($sformatf("ERROR pixel.h/v: got %h/%h with timer at %h/%h",
                    pixel.h, pixel.v, timer.hdump, timer.vdump));
            exp_pc = ref_pixel(pixel.h, pixel.v);
            assert ({pixel.palette, pixel.colour} == exp_pc) else stop_on_error($sformatf(
                "ERROR pixel palette/colour at (%0d,%0d): got %h expected %h",
                pixel.h, pixel.v, {pixel.palette, pixel.colour}, exp_pc));
            checked++;
            if (count_en)
                seen[pixel.h][pixel.v]++;
        end
    end

    initial begin
        void'($urandom(29502));
        for (int i = 0; i < 256; i++)
            rom_delay[i] = 4'(1 + $urandom % 8);
        rst      = 1'b1;
        mode_cs  = 1'b0;
        sft_cs   = 1'b0;
        map_cs   = 1'b0;
        cpu_dout = '0;
        cpu_addr = '0;
        cpu_rnw  = 1'b1;
        cpu_dsn  = 2'b11;
        rom_data = '0;
        rom_ok   = 1'b0;
        rom_idx  = '0;
        rom_wait = 0;
        checked  = 0;
        count_en = 1'b0;
        for (int i = 0; i < 4; i++) begin
            mode_m[i]   = '0;
            scroll_m[i] = '0;
        end
        repeat (8) @(negedge clk);
        assert (!rom_cs && !pixel.valid && !timer.hs && !timer.vs && !timer.cen && !pxl2_cen)
            else stop_on_error("outputs not low at the end of reset");
        count_en = 1'b1;
        rst      = 1'b0;

        // Disabled layer, first frame covers the screen once
        wait_vblank_start();
        count_en = 1'b0;
        for (int x = 0; x < `TM_H_VISIBLE; x++)
            for (int y = 0; y < `TM_V_VISIBLE; y++)
                assert (seen[x][y] == 1) else stop_on_error($sformatf(
                    "visible pixel (%0d,%0d) seen %0d times in the first frame",
                    x, y, seen[x][y]));

        register_test();                           // All inside this blanking
        set_layer(1'b0, 2'd0, 16'd0, 16'd0);
        map_test();

        // Unscrolled, two frames
        wait_vblank_start();
        set_layer(1'b1, 2'd0, 16'd0, 16'd0);
        checked = 0;
        wait_vblank_start();
        wait_vblank_start();
        assert (checked == 2 * `TM_H_VISIBLE * `TM_V_VISIBLE)
            else stop_on_error("wrong pixel count over two enabled frames");

        // Scroll near 256 so both axes wrap
        set_layer(1'b1, 2'(1 + $urandom % 3), 16'(200 + $urandom % 56),
                  16'(230 + $urandom % 26));
        checked = 0;
        wait_vblank_start();
        assert (checked == `TM_H_VISIBLE * `TM_V_VISIBLE)
            else stop_on_error("wrong pixel count in the scrolled frame");

        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== bac06_tilemap.f ====
+incdir+design
design/cpu_bus_pkg.sv
design/video_pkg.sv
design/tile_mmr.sv
design/tile_map_ram.sv
design/video_timer.sv
design/tile_render.sv
design/bac06_tilemap.sv
tests/bac06_tilemap_tb.sv

// ==== Bender.yml ====
package:
  name: bac06_tilemap

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_bus_pkg.sv
      - design/video_pkg.sv
      - design/tile_mmr.sv
      - design/tile_map_ram.sv
      - design/video_timer.sv
      - design/tile_render.sv
      - design/bac06_tilemap.sv
      - target: test
        files:
          - tests/bac06_tilemap_tb.sv
